// File: design/decodePkg.sv
package decodePkg;

    localparam int LaneCount   = 2;   // instructions per bundle, also runs with 1 or 4
    localparam int InstWidth   = 32;
    localparam int RegWidth    = 64;  // datapath and immediate width
    localparam int AluCtlWidth = 5;
    localparam int SelBWidth   = 2;
    localparam int BranchWidth = 3;
    localparam int MemOpWidth  = 3;
    localparam int RegSrcWidth = 2;
    localparam int FmtWidth    = 3;

    // major opcodes
    localparam logic [6:0] opOpImm   = 7'b0010011;
    localparam logic [6:0] opOpImm32 = 7'b0011011;
    localparam logic [6:0] opOp      = 7'b0110011;
    localparam logic [6:0] opOp32    = 7'b0111011;
    localparam logic [6:0] opAuipc   = 7'b0010111;
    localparam logic [6:0] opLui     = 7'b0110111;
    localparam logic [6:0] opStore   = 7'b0100011;
    localparam logic [6:0] opLoad    = 7'b0000011;
    localparam logic [6:0] opBranch  = 7'b1100011;
    localparam logic [6:0] opJal     = 7'b1101111;
    localparam logic [6:0] opJalr    = 7'b1100111;
    localparam logic [6:0] opSystem  = 7'b1110011;

    // instruction formats
    localparam logic [FmtWidth-1:0] fmtNone = 3'd0;
    localparam logic [FmtWidth-1:0] fmtR    = 3'd1;
    localparam logic [FmtWidth-1:0] fmtI    = 3'd2;
    localparam logic [FmtWidth-1:0] fmtS    = 3'd3;
    localparam logic [FmtWidth-1:0] fmtB    = 3'd4;
    localparam logic [FmtWidth-1:0] fmtU    = 3'd5;
    localparam logic [FmtWidth-1:0] fmtJ    = 3'd6;

    localparam logic [AluCtlWidth-1:0] aluAdd   = 5'b00000;
    localparam logic [AluCtlWidth-1:0] aluPassB = 5'b00011;
    localparam logic [AluCtlWidth-1:0] aluSltu  = 5'b01010;  // unsigned compare

    localparam logic aSelPc  = 1'b0;
    localparam logic aSelRs1 = 1'b1;

    localparam logic [SelBWidth-1:0] bSelImm  = 2'd0;
    localparam logic [SelBWidth-1:0] bSelRs2  = 2'd1;
    localparam logic [SelBWidth-1:0] bSelFour = 2'd2;  // link address pc + 4

    localparam logic [BranchWidth-1:0] brSeq  = 3'b010;
    localparam logic [BranchWidth-1:0] brJal  = 3'b110;
    localparam logic [BranchWidth-1:0] brJalr = 3'b111;

    localparam logic [MemOpWidth-1:0] memNone = 3'b000;
    localparam logic [MemOpWidth-1:0] memD    = 3'b100;
    localparam logic [MemOpWidth-1:0] memWu   = 3'b001;
    localparam logic [MemOpWidth-1:0] memHu   = 3'b010;
    localparam logic [MemOpWidth-1:0] memBu   = 3'b011;
    localparam logic [MemOpWidth-1:0] memW    = 3'b101;
    localparam logic [MemOpWidth-1:0] memH    = 3'b110;
    localparam logic [MemOpWidth-1:0] memB    = 3'b111;

    localparam logic [RegSrcWidth-1:0] srcAlu = 2'd0;
    localparam logic [RegSrcWidth-1:0] srcMem = 2'd1;
    localparam logic [RegSrcWidth-1:0] srcCsr = 2'd2;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm11to0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] imm11to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4to0;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm31to12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } rvInst_u;

endpackage

// File: design/ImmGen.sv
`timescale 1ns/1ps

module ImmGen import decodePkg::*; (
    input  rvInst_u               inst,
    input  logic [FmtWidth-1:0]   format,
    output logic [RegWidth-1:0]   imm
);

    always_comb begin
        case (format)
            fmtI: begin
                imm = {{(RegWidth-12){inst.iType.imm11to0[11]}}, inst.iType.imm11to0};
            end
            fmtS: begin
                imm = {{(RegWidth-12){inst.sType.imm11to5[6]}},
                       inst.sType.imm11to5, inst.sType.imm4to0};
            end
            fmtB: begin
                imm = {{(RegWidth-13){inst.bType.imm12}}, inst.bType.imm12,
                       inst.bType.imm11, inst.bType.imm10to5,
                       inst.bType.imm4to1, 1'b0};               // halfword aligned
            end
            fmtU: begin
                imm = {{(RegWidth-32){inst.uType.imm31to12[19]}},
                       inst.uType.imm31to12, 12'b0};
            end
            fmtJ: begin
                imm = {{(RegWidth-21){inst.jType.imm20}}, inst.jType.imm20,
                       inst.jType.imm19to12, inst.jType.imm11,
                       inst.jType.imm10to1, 1'b0};
            end
            default: imm = '0;                                  // R type and unknown
        endcase
    end

endmodule

// File: design/ContrGen.sv
`timescale 1ns/1ps

module ContrGen import decodePkg::*; (
    input  rvInst_u                 inst,
    output logic [AluCtlWidth-1:0]  aluCtl,
    output logic [RegWidth-1:0]     imm,
    output logic                    aluASel,
    output logic [SelBWidth-1:0]    aluBSel,
    output logic [BranchWidth-1:0]  branch,
    output logic                    regWr,
    output logic                    memWr,
    output logic [MemOpWidth-1:0]   memOp,
    output logic [RegSrcWidth-1:0]  regSrc,
    output logic                    isTruncate,
    output logic                    isSext,
    output logic                    intrEn,
    output logic                    illegal
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [FmtWidth-1:0]    format;
    logic                   isCondBr, isJal, isJalr, isMul, isSub;
    logic [AluCtlWidth-1:0] intAluCtl, mulAluCtl;

    assign opcode = inst.rType.opcode;
    assign funct3 = inst.rType.funct3;
    assign funct7 = inst.rType.funct7;

    always_comb begin
        case (opcode)
            opOpImm, opOpImm32, opLoad, opJalr, opSystem: format = fmtI;
            opOp, opOp32:                                 format = fmtR;
            opAuipc, opLui:                               format = fmtU;
            opStore:                                      format = fmtS;
            opBranch:                                     format = fmtB;
            opJal:                                        format = fmtJ;
            default:                                      format = fmtNone;
        endcase
    end

    assign isCondBr = (format == fmtB);
    assign isJal    = (opcode == opJal);
    assign isJalr   = (opcode == opJalr);
    assign branch   = isCondBr ? (funct3 & 3'b101) : isJal ? brJal : isJalr ? brJalr : brSeq;

    // funct7[5] selects sub/sra, only meaningful on register ops and right shifts
    assign isMul     = ((opcode == opOp) || (opcode == opOp32)) && funct7[0];
    assign isSub     = funct7[5] & (opcode[5] | (funct3 == 3'b101));
    assign intAluCtl = (funct3 == 3'b011) ? aluSltu : {1'b0, isSub, funct3};
    assign mulAluCtl = {1'b1, funct3[0], funct3};   // funct3[0] picks signedness

    always_comb begin
        if ((opcode == opAuipc) || (opcode == opLoad) || (opcode == opStore) || isJal || isJalr)
            aluCtl = aluAdd;
        else if (isCondBr)
            aluCtl = {1'b0, funct3[1], 3'b010};     // subtract compare
        else if (opcode == opLui)
            aluCtl = aluPassB;
        else if (isMul)
            aluCtl = mulAluCtl;
        else
            aluCtl = intAluCtl;
    end

    assign aluASel = (((format == fmtI) && !isJalr) || (format == fmtR) ||
                      (format == fmtS) || (format == fmtB)) ? aSelRs1 : aSelPc;
    assign aluBSel = (isJal || isJalr) ? bSelFour :
                     ((format == fmtR) || (format == fmtB)) ? bSelRs2 : bSelImm;

    assign regWr  = ((format == fmtR) || (format == fmtI) || (format == fmtU) ||
                     (format == fmtJ)) && !illegal;
    assign regSrc = (opcode == opLoad) ? srcMem : (opcode == opSystem) ? srcCsr : srcAlu;
    assign intrEn = (opcode == opSystem) && !illegal;

    always_comb begin
        memWr      = 1'b0;
        memOp      = memNone;
        isTruncate = 1'b0;
        isSext     = 1'b0;
        illegal    = 1'b0;
        casez ({funct7, funct3, opcode})
            {7'b???????, 3'b???, opLui},
            {7'b???????, 3'b???, opAuipc},
            {7'b???????, 3'b???, opJal},
            {7'b???????, 3'b000, opJalr},
            {7'b???????, 3'b00?, opBranch},                 // beq bne
            {7'b???????, 3'b1??, opBranch},                 // blt bge bltu bgeu
            {7'b???????, 3'b000, opOpImm},
            {7'b???????, 3'b01?, opOpImm},                  // slti sltiu
            {7'b???????, 3'b1?0, opOpImm},                  // xori ori
            {7'b???????, 3'b111, opOpImm},
            {7'b000000?, 3'b001, opOpImm},                  // slli, 6-bit shamt
            {7'b0?0000?, 3'b101, opOpImm},                  // srli srai
            {7'b000000?, 3'b???, opOp},                     // base ops and mul/div
            {7'b0100000, 3'b000, opOp},
            {7'b0100000, 3'b101, opOp},
            {7'b???????, 3'b???, opSystem}: ;               // no memory side
            {7'b???????, 3'b000, opLoad}: memOp = memB;
            {7'b???????, 3'b001, opLoad}: memOp = memH;
            {7'b???????, 3'b010, opLoad}: memOp = memW;
            {7'b???????, 3'b011, opLoad}: memOp = memD;
            {7'b???????, 3'b100, opLoad}: memOp = memBu;
            {7'b???????, 3'b101, opLoad}: memOp = memHu;
            {7'b???????, 3'b110, opLoad}: memOp = memWu;
            {7'b???????, 3'b000, opStore}: begin
                memWr = 1'b1;
                memOp = memBu;
            end
            {7'b???????, 3'b001, opStore}: begin
                memWr = 1'b1;
                memOp = memHu;
            end
            {7'b???????, 3'b010, opStore}: begin
                memWr = 1'b1;
                memOp = memWu;
            end
            {7'b???????, 3'b011, opStore}: begin
                memWr = 1'b1;
                memOp = memD;
            end
            {7'b???????, 3'b000, opOpImm32},                // addiw
            {7'b0000000, 3'b001, opOpImm32},
            {7'b0?00000, 3'b101, opOpImm32},
            {7'b0000000, 3'b00?, opOp32},                   // addw sllw
            {7'b0?00000, 3'b101, opOp32},                   // srlw sraw
            {7'b0100000, 3'b000, opOp32},
            {7'b0000001, 3'b000, opOp32},                   // mulw
            {7'b0000001, 3'b1??, opOp32}: begin             // divw divuw remw remuw
                isTruncate = 1'b1;
                isSext     = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    ImmGen immGen (
        .inst   (inst),
        .format (format),
        .imm    (imm)
    );

endmodule

// File: design/FetchLatch.sv
`timescale 1ns/1ps

module FetchLatch import decodePkg::*; (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 fetchValid,
    input  logic [LaneCount-1:0][InstWidth-1:0]  fetchInst,
    input  logic [LaneCount-1:0]                 fetchLaneValid,
    output logic [LaneCount-1:0][InstWidth-1:0]  latInst,
    output logic [LaneCount-1:0]                 latValid
);

    // valid drops on any edge without a strobe, so a bundle decodes once
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            latValid <= '0;
        end else begin
            latValid <= fetchValid ? fetchLaneValid : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            latInst <= fetchInst;                   // held until next strobe
        end
    end

endmodule

// File: design/DecodeReg.sv
`timescale 1ns/1ps

module DecodeReg import decodePkg::*; (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic [LaneCount-1:0]                    latValid,
    input  logic [LaneCount-1:0][AluCtlWidth-1:0]   aluCtl,
    input  logic [LaneCount-1:0][RegWidth-1:0]      imm,
    input  logic [LaneCount-1:0]                    aluASel,
    input  logic [LaneCount-1:0][SelBWidth-1:0]     aluBSel,
    input  logic [LaneCount-1:0][BranchWidth-1:0]   branch,
    input  logic [LaneCount-1:0]                    regWr,
    input  logic [LaneCount-1:0]                    memWr,
    input  logic [LaneCount-1:0][MemOpWidth-1:0]    memOp,
    input  logic [LaneCount-1:0][RegSrcWidth-1:0]   regSrc,
    input  logic [LaneCount-1:0]                    isTruncate,
    input  logic [LaneCount-1:0]                    isSext,
    input  logic [LaneCount-1:0]                    intrEn,
    input  logic [LaneCount-1:0]                    illegal,
    output logic [LaneCount-1:0]                    decValid,
    output logic [LaneCount-1:0][AluCtlWidth-1:0]   decAluCtl,
    output logic [LaneCount-1:0][RegWidth-1:0]      decImm,
    output logic [LaneCount-1:0]                    decAluASel,
    output logic [LaneCount-1:0][SelBWidth-1:0]     decAluBSel,
    output logic [LaneCount-1:0][BranchWidth-1:0]   decBranch,
    output logic [LaneCount-1:0]                    decRegWr,
    output logic [LaneCount-1:0]                    decMemWr,
    output logic [LaneCount-1:0][MemOpWidth-1:0]    decMemOp,
    output logic [LaneCount-1:0][RegSrcWidth-1:0]   decRegSrc,
    output logic [LaneCount-1:0]                    decIsTruncate,
    output logic [LaneCount-1:0]                    decIsSext,
    output logic [LaneCount-1:0]                    decIntrEn,
    output logic [LaneCount-1:0]                    decIllegal
);

    logic [LaneCount-1:0] laneOk;

    // younger lanes die behind a valid illegal one; the illegal lane itself survives
    always_comb begin
        logic blocked;
        blocked = 1'b0;
        for (int i = 0; i < LaneCount; i++) begin
            laneOk[i] = latValid[i] & ~blocked;
            blocked   = blocked | (latValid[i] & illegal[i]);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid      <= '0;
            decAluCtl     <= '0;
            decAluASel    <= '0;
            decAluBSel    <= '0;
            decBranch     <= '0;
            decRegWr      <= '0;
            decMemWr      <= '0;
            decMemOp      <= '0;
            decRegSrc     <= '0;
            decIsTruncate <= '0;
            decIsSext     <= '0;
            decIntrEn     <= '0;
            decIllegal    <= '0;
        end else begin
            decValid      <= laneOk;
            decAluCtl     <= aluCtl;
            decAluASel    <= aluASel;
            decAluBSel    <= aluBSel;
            decBranch     <= branch;
            decRegWr      <= regWr & laneOk;        // dead lanes write nothing
            decMemWr      <= memWr & laneOk;
            decMemOp      <= memOp;
            decRegSrc     <= regSrc;
            decIsTruncate <= isTruncate;
            decIsSext     <= isSext;
            decIntrEn     <= intrEn & laneOk;
            decIllegal    <= illegal & laneOk;
        end
    end

    always_ff @(posedge clk) begin
        decImm <= imm;
    end

endmodule

// File: design/DecodeStage.sv
`timescale 1ns/1ps

module DecodeStage import decodePkg::*; (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    fetchValid,
    input  logic [LaneCount-1:0][InstWidth-1:0]     fetchInst,
    input  logic [LaneCount-1:0]                    fetchLaneValid,
    output logic [LaneCount-1:0]                    decValid,
    output logic [LaneCount-1:0][AluCtlWidth-1:0]   decAluCtl,
    output logic [LaneCount-1:0][RegWidth-1:0]      decImm,
    output logic [LaneCount-1:0]                    decAluASel,
    output logic [LaneCount-1:0][SelBWidth-1:0]     decAluBSel,
    output logic [LaneCount-1:0][BranchWidth-1:0]   decBranch,
    output logic [LaneCount-1:0]                    decRegWr,
    output logic [LaneCount-1:0]                    decMemWr,
    output logic [LaneCount-1:0][MemOpWidth-1:0]    decMemOp,
    output logic [LaneCount-1:0][RegSrcWidth-1:0]   decRegSrc,
    output logic [LaneCount-1:0]                    decIsTruncate,
    output logic [LaneCount-1:0]                    decIsSext,
    output logic [LaneCount-1:0]                    decIntrEn,
    output logic [LaneCount-1:0]                    decIllegal
);

    logic [LaneCount-1:0][InstWidth-1:0]    latInst;
    logic [LaneCount-1:0]                   latValid;
    logic [LaneCount-1:0][AluCtlWidth-1:0]  aluCtl;
    logic [LaneCount-1:0][RegWidth-1:0]     imm;
    logic [LaneCount-1:0]                   aluASel;
    logic [LaneCount-1:0][SelBWidth-1:0]    aluBSel;
    logic [LaneCount-1:0][BranchWidth-1:0]  branch;
    logic [LaneCount-1:0]                   regWr, memWr;
    logic [LaneCount-1:0][MemOpWidth-1:0]   memOp;
    logic [LaneCount-1:0][RegSrcWidth-1:0]  regSrc;
    logic [LaneCount-1:0]                   isTruncate, isSext, intrEn, illegal;

    FetchLatch fetchLatch (
        .clk            (clk),
        .rstN           (rstN),
        .fetchValid     (fetchValid),
        .fetchInst      (fetchInst),
        .fetchLaneValid (fetchLaneValid),
        .latInst        (latInst),
        .latValid       (latValid)
    );

    for (genvar lane = 0; lane < LaneCount; lane++) begin : genLane
        ContrGen contrGen (
            .inst       (latInst[lane]),
            .aluCtl     (aluCtl[lane]),
            .imm        (imm[lane]),
            .aluASel    (aluASel[lane]),
            .aluBSel    (aluBSel[lane]),
            .branch     (branch[lane]),
            .regWr      (regWr[lane]),
            .memWr      (memWr[lane]),
            .memOp      (memOp[lane]),
            .regSrc     (regSrc[lane]),
            .isTruncate (isTruncate[lane]),
            .isSext     (isSext[lane]),
            .intrEn     (intrEn[lane]),
            .illegal    (illegal[lane])
        );
    end

    DecodeReg decodeReg (
        .clk (clk), .rstN (rstN), .latValid (latValid),
        .aluCtl (aluCtl), .imm (imm), .aluASel (aluASel), .aluBSel (aluBSel),
        .branch (branch), .regWr (regWr), .memWr (memWr), .memOp (memOp),
        .regSrc (regSrc), .isTruncate (isTruncate), .isSext (isSext),
        .intrEn (intrEn), .illegal (illegal),
        .decValid      (decValid),
        .decAluCtl     (decAluCtl),
        .decImm        (decImm),
        .decAluASel    (decAluASel),
        .decAluBSel    (decAluBSel),
        .decBranch     (decBranch),
        .decRegWr      (decRegWr),
        .decMemWr      (decMemWr),
        .decMemOp      (decMemOp),
        .decRegSrc     (decRegSrc),
        .decIsTruncate (decIsTruncate),
        .decIsSext     (decIsSext),
        .decIntrEn     (decIntrEn),
        .decIllegal    (decIllegal)
    );

endmodule

// File: bench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);                             // release away from the rising edge
        rstN = 1'b1;
    end

endmodule

// File: bench/decodeTb.sv
`timescale 1ns/1ps

module decodeTb import decodePkg::*; ();

    localparam int FieldsPerLane = 11;              // expected columns per lane
    localparam int CheckedFields = 14;              // file columns plus opcode-derived fields

    logic                                   clk, rstN;
    logic                                   fetchValid;
    logic [LaneCount-1:0][InstWidth-1:0]    fetchInst;
    logic [LaneCount-1:0]                   fetchLaneValid;
    logic [LaneCount-1:0]                   decValid, decAluASel, decRegWr, decMemWr;
    logic [LaneCount-1:0]                   decIsTruncate, decIsSext, decIntrEn, decIllegal;
    logic [LaneCount-1:0][AluCtlWidth-1:0]  decAluCtl;
    logic [LaneCount-1:0][RegWidth-1:0]     decImm;
    logic [LaneCount-1:0][SelBWidth-1:0]    decAluBSel;
    logic [LaneCount-1:0][BranchWidth-1:0]  decBranch;
    logic [LaneCount-1:0][MemOpWidth-1:0]   decMemOp;
    logic [LaneCount-1:0][RegSrcWidth-1:0]  decRegSrc;

    string       names[$];
    logic [31:0] instA[$], instB[$];
    logic [1:0]  laneMask[$];
    logic [63:0] expVals[$];                        // FieldsPerLane values per lane, per test
    int          issueIdx[$], issueCycle[$];        // bundles in flight
    int          cycle = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    bit          loaded = 1'b0;
    string       fieldNames[CheckedFields] = '{"decValid", "aluCtl", "imm", "aluBSel",
        "branch", "regWr", "memWr", "memOp", "isTruncate", "isSext", "illegal",
        "aluASel", "regSrc", "intrEn"};

    tbClock clockGen (.clk(clk), .rstN(rstN));

    DecodeStage UUT (.*);

    function automatic logic [63:0] actualField(input int lane, input int k);
        case (k)
            0: return 64'(decValid[lane]);
            1: return 64'(decAluCtl[lane]);
            2: return decImm[lane];
            3: return 64'(decAluBSel[lane]);
            4: return 64'(decBranch[lane]);
            5: return 64'(decRegWr[lane]);
            6: return 64'(decMemWr[lane]);
            7: return 64'(decMemOp[lane]);
            8: return 64'(decIsTruncate[lane]);
            9: return 64'(decIsSext[lane]);
            10: return 64'(decIllegal[lane]);
            11: return 64'(decAluASel[lane]);
            12: return 64'(decRegSrc[lane]);
            default: return 64'(decIntrEn[lane]);
        endcase
    endfunction

    // operand A, writeback source and interrupt enable depend on the opcode only
    function automatic logic [63:0] opcodeExpected(input logic [31:0] inst, input int k);
        logic [6:0] op;
        logic       usesPc;
        op     = inst[6:0];
        usesPc = (op == opLui) || (op == opAuipc) || (op == opJal) || (op == opJalr);
        case (k)
            11: return usesPc ? 64'(aSelPc) : 64'(aSelRs1);
            12: return (op == opLoad) ? 64'(srcMem) :
                       (op == opSystem) ? 64'(srcCsr) : 64'(srcAlu);
            default: return 64'(op == opSystem);
        endcase
    endfunction

    task automatic compareField(input string test, input int lane, input int k,
                                input logic [63:0] expected);
        logic [63:0] actual;
        actual = actualField(lane, k);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("[ERROR] %s lane %0d %s: expected %0h, actual %0h",
                     test, lane, fieldNames[k], expected, actual);
        end
    endtask

    task automatic checkOutputs();
        int          t;
        int          due;
        int          base;
        logic        full;
        logic [31:0] inst;
        if (decValid !== '0) begin
            checkCount++;
            assert (issueIdx.size() != 0) else begin
                errorCount++;
                $display("decValid is %b while no bundle is in flight", decValid);
            end
            if (issueIdx.size() != 0) begin
                t   = issueIdx.pop_front();
                due = issueCycle.pop_front() + 2;
                checkCount++;
                assert (cycle == due) else begin
                    errorCount++;
                    $display("test %s reached the outputs at cycle %0d, due at cycle %0d",
                             names[t], cycle, due);
                end
                for (int lane = 0; lane < LaneCount; lane++) begin
                    base = (t * LaneCount + lane) * FieldsPerLane;
                    full = (expVals[base] == 1) && (expVals[base + 10] == 0);
                    inst = (lane == 0) ? instA[t] : instB[t];
                    for (int k = 0; k < FieldsPerLane; k++) begin
                        // dead or illegal lanes only promise no side effects
                        if (full || k == 0 || k == 5 || k == 6 || k == 10)
                            compareField(names[t], lane, k, expVals[base + k]);
                    end
                    if (full) begin
                        compareField(names[t], lane, 11, opcodeExpected(inst, 11));
                        compareField(names[t], lane, 12, opcodeExpected(inst, 12));
                    end
                    compareField(names[t], lane, 13,
                                 full ? opcodeExpected(inst, 13) : 64'd0);
                end
            end
        end else begin
            if (issueCycle.size() > 0) begin
                checkCount++;
                assert (issueCycle[0] + 2 != cycle) else begin
                    errorCount++;
                    $display("test %s shows no valid lane when it is due",
                             names[issueIdx[0]]);
                end
            end
            for (int lane = 0; lane < LaneCount; lane++) begin
                compareField("idle", lane, 5, 64'd0);
                compareField("idle", lane, 6, 64'd0);
                compareField("idle", lane, 13, 64'd0);
            end
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        cycle++;
        checkOutputs();
    endtask

    task automatic loadTests();
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [63:0] vals[25];
        fd = $fopen("bench/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/decode_tests.txt");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            code = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, vals[0], vals[1], vals[2], vals[3], vals[4], vals[5], vals[6], vals[7],
                vals[8], vals[9], vals[10], vals[11], vals[12], vals[13], vals[14], vals[15],
                vals[16], vals[17], vals[18], vals[19], vals[20], vals[21], vals[22], vals[23],
                vals[24]);
            if (code != 26) begin
                $display("malformed line in the test file: %s", line);
                errorCount++;
                continue;
            end
            names.push_back(name);
            instA.push_back(vals[0][31:0]);
            instB.push_back(vals[1][31:0]);
            laneMask.push_back(vals[2][1:0]);
            for (int k = 3; k < 25; k++)
                expVals.push_back(vals[k]);
        end
        $fclose(fd);
        if (names.size() == 0) begin
            $display("no tests were read from the test file");
            errorCount++;
        end
    endtask

    task automatic finishRun();
        $display("decodeTb: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        int gap;
        void'($urandom(32'h2ffd));
        fetchValid     = 1'b0;
        fetchInst      = '0;
        fetchLaneValid = '0;
        loadTests();
        loaded = 1'b1;
        wait (rstN === 1'b1);
        for (int t = 0; t < names.size(); t++) begin
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                stepCycle();
                fetchValid     = 1'b0;
                fetchLaneValid = '1;                // lane bits without a strobe are ignored
            end
            stepCycle();
            fetchValid     = 1'b1;
            fetchInst[0]   = instA[t];
            fetchInst[1]   = instB[t];
            fetchLaneValid = laneMask[t];
            issueIdx.push_back(t);
            issueCycle.push_back(cycle);
        end
        repeat (3) begin
            stepCycle();
            fetchValid = 1'b0;
        end
        checkCount++;
        assert (issueIdx.size() == 0) else begin
            errorCount++;
            $display("%0d bundles never reached the outputs", issueIdx.size());
        end
        finishRun();
    end

    // at most three cycles per test, plus reset and drain
    initial begin
        wait (loaded);
        repeat (names.size() * 4 + 20) @(posedge clk);
        $display("timeout: the run did not finish in time");
        errorCount++;
        finishRun();
    end

endmodule

// File: bench/decode_tests.txt
# name inst0 inst1 laneMask, then per lane: valid aluCtl imm aluBSel branch
# regWr memWr memOp isTruncate isSext illegal, all hex
add_sub 002081b3 40208233 3 1 00 0 1 2 1 0 0 0 0 0 1 08 0 1 2 1 0 0 0 0 0
sltu_addi 0020b2b3 ffb00093 3 1 0a 0 1 2 1 0 0 0 0 0 1 00 fffffffffffffffb 0 2 1 0 0 0 0 0
srai_lui 4033d313 12345437 3 1 0d 403 0 2 1 0 0 0 0 0 1 03 12345000 0 2 1 0 0 0 0 0
lui_auipc 800004b7 00001517 3 1 03 ffffffff80000000 0 2 1 0 0 0 0 0 1 00 1000 0 2 1 0 0 0 0 0
lb_lhu fff10583 00615603 3 1 00 ffffffffffffffff 0 2 1 0 7 0 0 0 1 00 6 0 2 1 0 2 0 0 0
lw_ld 00812683 01013703 3 1 00 8 0 2 1 0 5 0 0 0 1 00 10 0 2 1 0 4 0 0 0
sb_sh fe510c23 00511123 3 1 00 fffffffffffffff8 0 2 0 1 3 0 0 0 1 00 2 0 2 0 1 2 0 0 0
sw_sd 00512623 fe513823 3 1 00 c 0 2 0 1 1 0 0 0 1 00 fffffffffffffff0 0 2 0 1 4 0 0 0
beq_bltu 00208863 fe20eee3 3 1 02 10 1 0 0 0 0 0 0 0 1 0a fffffffffffffffc 1 4 0 0 0 0 0 0
jal_jalr 001000ef 004280e7 3 1 00 800 2 6 1 0 0 0 0 0 1 00 4 2 7 1 0 0 0 0 0
jal_back ff9ff06f 002081b3 3 1 00 fffffffffffffff8 2 6 1 0 0 0 0 0 1 00 0 1 2 1 0 0 0 0 0
addw_sraiw 002081bb 4033d31b 3 1 00 0 1 2 1 0 0 1 1 0 1 0d 403 0 2 1 0 0 1 1 0
mulw_divuw 022081bb 0220d1bb 3 1 10 0 1 2 1 0 0 1 1 0 1 1d 0 1 2 1 0 0 1 1 0
mul_add 022081b3 002081b3 3 1 10 0 1 2 1 0 0 0 0 0 1 00 0 1 2 1 0 0 0 0 0
ill_lane0 0000000b 002081b3 3 1 00 0 0 0 0 0 0 0 0 1 0 00 0 0 0 0 0 0 0 0 0
ill_lane1 002081b3 0000000b 3 1 00 0 1 2 1 0 0 0 0 0 1 00 0 0 0 0 0 0 0 0 1
ill_masked 0000000b 002081b3 2 0 00 0 0 0 0 0 0 0 0 0 1 00 0 1 2 1 0 0 0 0 0
only_lane0 00812683 fe513823 1 1 00 8 0 2 1 0 5 0 0 0 0 00 0 0 0 0 0 0 0 0 0
only_lane1 fe513823 00812683 2 0 00 0 0 0 0 0 0 0 0 0 1 00 8 0 2 1 0 5 0 0 0
add_again 002081b3 40208233 3 1 00 0 1 2 1 0 0 0 0 0 1 08 0 1 2 1 0 0 0 0 0

// File: flist.f
design/decodePkg.sv
design/ImmGen.sv
design/ContrGen.sv
design/FetchLatch.sv
design/DecodeReg.sv
design/DecodeStage.sv
bench/tbClock.sv
bench/decodeTb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - design/decodePkg.sv
  - design/ImmGen.sv
  - design/ContrGen.sv
  - design/FetchLatch.sv
  - design/DecodeReg.sv
  - design/DecodeStage.sv
  - target: test
    files:
      - bench/tbClock.sv
      - bench/decodeTb.sv
